// ==== list.f ====
source/trace_pkg.sv
source/commit_capture.sv
source/trace_fifo.sv
source/trace_arbiter.sv
source/commit_trace.sv
test/tb_clock.sv
test/tb_commit_trace.sv

// ==== Makefile ====
# Verilator build and run of the commit trace testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_trace
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_commit_trace.sv ====
/* Commit trace testbench: stimulus, reference queue model,
   concurrent output checks, watchdog and final report */
`timescale 1ns/100ps

module tb_commit_trace;

  localparam int unsigned NrPorts   = 2;
  localparam int unsigned Depth     = 4;
  localparam int unsigned IdxW      = (NrPorts > 1) ? $clog2(NrPorts) : 1;
  localparam int unsigned ClkPeriod = 4;
  localparam int unsigned Seed      = 53870;

  // Test lengths in cycles
  localparam int unsigned DirectedCycles = 16;
  localparam int unsigned RandomCycles   = 300;
  localparam int unsigned StallCycles    = 16;
  localparam int unsigned BusyCycles     = 8;
  localparam int unsigned DrainLimit     = 40;
  localparam int unsigned TotalCycles    = DirectedCycles + RandomCycles + StallCycles
                                         + BusyCycles + DrainLimit + 2;
  localparam int unsigned TimeoutNs      = (TotalCycles * 2 + 40) * ClkPeriod;

  typedef logic [NrPorts-1:0] port_mask_t;

  logic                                   clk, rst_n;
  trace_pkg::commit_entry_t [NrPorts-1:0] commit_instr;
  port_mask_t                             commit_ack;
  trace_pkg::priv_lvl_t                   priv_lvl;
  logic                                   debug_mode, trace_ready, trace_valid;
  trace_pkg::trace_rec_t                  trace_rec;
  logic [IdxW-1:0]                        trace_port;
  logic [15:0]                            drop_count;

  // Reference model state
  trace_pkg::trace_rec_t            ref_q [NrPorts][$];
  trace_pkg::trace_rec_t            st_rec [NrPorts];
  port_mask_t                       st_valid;
  logic [trace_pkg::CycleWidth-1:0] cyc;
  int unsigned                      rr;
  logic [15:0]                      model_drop;
  logic                             exp_valid;
  logic [IdxW-1:0]                  exp_port;
  trace_pkg::trace_rec_t            exp_rec;
  logic [15:0]                      exp_drop;
  int                               val_errs = 0;
  int                               other_errs = 0;

  tb_clock #(.Period(ClkPeriod), .ResetCycles(2)) i_clock (.clk_o(clk), .rst_no(rst_n));

  commit_trace #(
    .NrCommitPorts  ( NrPorts      ),
    .FifoDepth      ( Depth        )
  ) uut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_instr_i ( commit_instr ),
    .commit_ack_i   ( commit_ack   ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .trace_ready_i  ( trace_ready  ),
    .trace_o        ( trace_rec    ),
    .trace_port_o   ( trace_port   ),
    .trace_valid_o  ( trace_valid  ),
    .drop_count_o   ( drop_count   )
  );

  function automatic trace_pkg::priv_lvl_t to_priv(input int sel);
    case (sel)
      0:       return trace_pkg::PRIV_LVL_U;
      1:       return trace_pkg::PRIV_LVL_S;
      default: return trace_pkg::PRIV_LVL_M;
    endcase
  endfunction

  function automatic trace_pkg::trace_rec_t build_expected(
    input trace_pkg::commit_entry_t ent, input trace_pkg::priv_lvl_t priv,
    input logic dbg, input logic [trace_pkg::CycleWidth-1:0] stamp);
    trace_pkg::trace_rec_t rec;
    rec.cycle    = stamp;
    rec.pc       = ent.pc;
    rec.insn     = ent.tval[31:0];
    if (dbg) rec.mode = trace_pkg::MODE_D;
    else if (priv == trace_pkg::PRIV_LVL_M) rec.mode = trace_pkg::MODE_M;
    else if (priv == trace_pkg::PRIV_LVL_S) rec.mode = trace_pkg::MODE_S;
    else rec.mode = trace_pkg::MODE_U;
    rec.ex_valid = ent.ex_valid;
    rec.cause    = ent.cause;
    return rec;
  endfunction

  function automatic int pending();
    int n;
    n = $countones(st_valid);
    for (int p = 0; p < NrPorts; p++) n += ref_q[p].size();
    return n;
  endfunction

  // --------------------------------------------------
  // Reference model, one step per clock edge
  // --------------------------------------------------
  always @(posedge clk or negedge rst_n) begin : model
    port_mask_t      full_now;
    logic            lock_n, found;
    logic [IdxW-1:0] port_n;
    int unsigned     idx;
    if (!rst_n) begin
      for (int p = 0; p < NrPorts; p++) ref_q[p].delete();
      st_valid = '0;
      cyc = '0;
      rr = 0;
      model_drop = '0;
      exp_valid <= 1'b0;
      exp_port <= '0;
      exp_rec <= '0;
      exp_drop <= '0;
    end else begin
      for (int p = 0; p < NrPorts; p++) full_now[p] = (ref_q[p].size() == Depth);
      lock_n = exp_valid && !trace_ready;
      if (exp_valid && trace_ready) begin
        void'(ref_q[exp_port].pop_front());
        rr = (int'(exp_port) + 1) % NrPorts;
      end
      for (int p = 0; p < NrPorts; p++) begin
        if (st_valid[p] && full_now[p]) begin
          if (model_drop != 16'hffff) model_drop = model_drop + 1'b1;
        end else if (st_valid[p]) begin
          ref_q[p].push_back(st_rec[p]);
        end
        st_valid[p] = commit_ack[p];
        st_rec[p] = build_expected(commit_instr[p], priv_lvl, debug_mode, cyc);
      end
      cyc = cyc + 1'b1;
      // Grant for the next cycle, held while stalled
      found = 1'b0;
      port_n = '0;
      for (int off = 0; off < NrPorts; off++) begin
        idx = (rr + off) % NrPorts;
        if (!found && ref_q[idx].size() != 0) begin
          found = 1'b1;
          port_n = IdxW'(idx);
        end
      end
      if (lock_n) port_n = exp_port;
      exp_valid <= found;
      exp_port <= port_n;
      exp_rec <= found ? ref_q[port_n][0] : '0;
      exp_drop <= model_drop;
    end
  end

  // --------------------------------------------------
  // Output checks
  // --------------------------------------------------
  reset_chk: assert property (@(posedge clk) $rose(rst_n) |-> !trace_valid && drop_count == '0)
    else begin
      other_errs++;
      $display("Outputs not idle right after reset");
    end

  valid_chk: assert property (@(posedge clk) disable iff (!rst_n) trace_valid == exp_valid)
    else begin
      val_errs++;
      $display("[ERROR] trace_valid_o exp %h got %h", $sampled(exp_valid), $sampled(trace_valid));
    end

  port_chk: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> trace_port == exp_port)
    else begin
      val_errs++;
      $display("[ERROR] trace_port_o exp %h got %h", $sampled(exp_port), $sampled(trace_port));
    end

  rec_chk: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> trace_rec == exp_rec)
    else begin
      val_errs++;
      $display("[ERROR] trace_o exp %h got %h", $sampled(exp_rec), $sampled(trace_rec));
    end

  drop_chk: assert property (@(posedge clk) disable iff (!rst_n) drop_count == exp_drop)
    else begin
      val_errs++;
      $display("[ERROR] drop_count_o exp %h got %h", $sampled(exp_drop), $sampled(drop_count));
    end

  hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_valid && !trace_ready) |=> $stable(trace_rec) && $stable(trace_port))
    else begin
      other_errs++;
      $display("Trace output changed while the sink stalled");
    end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic drive_cycle(input port_mask_t ack, input int priv_sel, input logic dbg,
                             input logic exc, input logic ready);
    trace_pkg::commit_entry_t [NrPorts-1:0] ent;
    for (int p = 0; p < NrPorts; p++) begin
      ent[p].pc       = {$urandom(), $urandom()};
      ent[p].tval     = {$urandom(), $urandom()};
      ent[p].ex_valid = exc && (p == 0);
      ent[p].cause    = 8'($urandom());
    end
    @(posedge clk);
    commit_instr <= ent;
    commit_ack   <= ack;
    priv_lvl     <= to_priv(priv_sel);
    debug_mode   <= dbg;
    trace_ready  <= ready;
  endtask

  initial begin
    commit_instr = '0;
    commit_ack   = '0;
    priv_lvl     = trace_pkg::PRIV_LVL_M;
    debug_mode   = 1'b0;
    trace_ready  = 1'b1;
    void'($urandom(Seed));
    wait (rst_n);
    // Single commits: M, S, debug over U, then an exception
    for (int k = 0; k < 4; k++) begin
      drive_cycle(port_mask_t'(k == 1 ? 2 : 1), (k == 1) ? 1 : (k == 2) ? 0 : 2,
                  k == 2, k == 3, 1'b1);
      repeat (3) drive_cycle('0, 2, 1'b0, 1'b0, 1'b1);
    end
    for (int k = 0; k < RandomCycles; k++) begin
      drive_cycle(port_mask_t'($urandom()), $urandom_range(0, 2), $urandom_range(0, 7) == 0,
                  $urandom_range(0, 3) == 0, $urandom_range(0, 3) != 0);
    end
    // Sink stalled while both ports commit every cycle
    repeat (StallCycles) drive_cycle('1, $urandom_range(0, 2), 1'b0, 1'b0, 1'b0);
    repeat (BusyCycles) drive_cycle('1, $urandom_range(0, 2), 1'b0, 1'b0, 1'b1);
    for (int k = 0; k < DrainLimit; k++) begin
      drive_cycle('0, 2, 1'b0, 1'b0, 1'b1);
      @(negedge clk);
      if (!trace_valid && pending() == 0) break;
    end
    @(negedge clk);
    if (trace_valid || pending() != 0) begin
      other_errs++;
      $display("Records still queued after the drain limit");
    end
    $display("Errors: %0d value, %0d other", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs * 1ns);
    $display("Run did not finish within %0d ns", TimeoutNs);
    $display("Errors: %0d value, %0d other", val_errs, other_errs + 1);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
/* Testbench clock and active-low reset source */
`timescale 1ns/100ps

module tb_clock #(
  parameter int unsigned Period      = 4,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release away from the sampling edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #(Period / 2) clk_o = ~clk_o;

endmodule

// ==== source/commit_trace.sv ====
/* Commit trace top level: capture, one queue per commit port
   and the round-robin output arbiter */
`timescale 1ns/100ps

module commit_trace #(
  parameter int unsigned NrCommitPorts = trace_pkg::NrCommitPorts,
  parameter int unsigned FifoDepth     = trace_pkg::FifoDepth,
  localparam int unsigned IdxW         = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  trace_pkg::commit_entry_t [NrCommitPorts-1:0] commit_instr_i,
  input  logic [NrCommitPorts-1:0]                     commit_ack_i,
  input  trace_pkg::priv_lvl_t                         priv_lvl_i,
  input  logic                                         debug_mode_i,
  input  logic                                         trace_ready_i,
  output trace_pkg::trace_rec_t                        trace_o,
  output logic [IdxW-1:0]                              trace_port_o,
  output logic                                         trace_valid_o,
  output logic [15:0]                                  drop_count_o
);

  // --------------------------------------------------
  // Capture to queues
  // --------------------------------------------------
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_push;
  logic [NrCommitPorts-1:0]                  push, full;

  // Queues to arbiter
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_head;
  logic [NrCommitPorts-1:0]                  pop, empty;

  commit_capture #(
    .NrPorts        ( NrCommitPorts  )
  ) i_capture (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .full_i         ( full           ),
    .rec_o          ( rec_push       ),
    .push_o         ( push           ),
    .drop_count_o   ( drop_count_o   )
  );

  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_queue
    trace_fifo #(
      .entry_t ( trace_pkg::trace_rec_t ),
      .Depth   ( FifoDepth              )
    ) i_fifo (
      .clk_i   ( clk_i       ),
      .rst_ni  ( rst_ni      ),
      .push_i  ( push[i]     ),
      .data_i  ( rec_push[i] ),
      .pop_i   ( pop[i]      ),
      .data_o  ( rec_head[i] ),
      .empty_o ( empty[i]    ),
      .full_o  ( full[i]     )
    );
  end

  trace_arbiter #(
    .NrPorts       ( NrCommitPorts          ),
    .entry_t       ( trace_pkg::trace_rec_t )
  ) i_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .data_i        ( rec_head      ),
    .empty_i       ( empty         ),
    .trace_ready_i ( trace_ready_i ),
    .pop_o         ( pop           ),
    .trace_o       ( trace_o       ),
    .trace_port_o  ( trace_port_o  ),
    .trace_valid_o ( trace_valid_o )
  );

endmodule

// ==== source/trace_arbiter.sv ====
/* Round-robin merge of queue heads onto one ready/valid trace output,
   grant held while the sink stalls */
`timescale 1ns/100ps

module trace_arbiter #(
  parameter int unsigned NrPorts = trace_pkg::NrCommitPorts,
  parameter type         entry_t = trace_pkg::trace_rec_t,
  localparam int unsigned IdxW   = (NrPorts > 1) ? $clog2(NrPorts) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  entry_t [NrPorts-1:0]      data_i,
  input  logic [NrPorts-1:0]        empty_i,
  input  logic                      trace_ready_i,
  output logic [NrPorts-1:0]        pop_o,
  output entry_t                    trace_o,
  output logic [IdxW-1:0]           trace_port_o,
  output logic                      trace_valid_o
);

  logic [IdxW-1:0] rr_q;
  logic [IdxW-1:0] sel;
  logic            found;
  logic            lock_q;
  logic [IdxW-1:0] lock_idx_q;
  logic            xfer;

  // --------------------------------------------------
  // Port selection
  // --------------------------------------------------
  // First non-empty port at or after the pointer
  always_comb begin
    int unsigned idx;
    sel   = '0;
    found = 1'b0;
    for (int unsigned off = 0; off < NrPorts; off++) begin
      idx = (rr_q + off) % NrPorts;
      if (!found && !empty_i[idx]) begin
        found = 1'b1;
        sel   = IdxW'(idx);
      end
    end
    // A stalled grant stays put so the output holds
    if (lock_q) sel = lock_idx_q;
  end

  assign trace_valid_o = |(~empty_i);
  assign trace_o       = data_i[sel];
  assign trace_port_o  = sel;
  assign xfer          = trace_valid_o & trace_ready_i;

  always_comb begin
    pop_o = '0;
    if (xfer) pop_o[sel] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= trace_valid_o & ~trace_ready_i;
      lock_idx_q <= sel;
      if (xfer) begin
        rr_q <= (sel == IdxW'(NrPorts - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  // Pop is one-hot and only ever hits a non-empty queue
  pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(pop_o) && ((pop_o & empty_i) == '0));

  // Stalled output must not change under the sink
  hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_valid_o && !trace_ready_i) |=> $stable(trace_o) && $stable(trace_port_o));

endmodule

// ==== source/trace_fifo.sv ====
/* Circular queue for any packed payload, with usage count
   and push/pop protocol checks */
`timescale 1ns/100ps

module trace_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned Depth   = 4
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned UsedW = $clog2(Depth + 1);

  entry_t             mem_q [Depth];
  logic [AddrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [UsedW-1:0]   usage_q;
  logic               do_push, do_pop;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == UsedW'(Depth));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == AddrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == AddrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  // Producer must watch full, consumer must watch empty
  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !push_i);

  no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> !pop_i);

endmodule

// ==== source/commit_capture.sv ====
/* Commit capture: cycle stamping, mode coding, record register,
   queue push and saturating drop counter */
`timescale 1ns/100ps

module commit_capture #(
  parameter int unsigned NrPorts = trace_pkg::NrCommitPorts
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  trace_pkg::commit_entry_t [NrPorts-1:0] commit_instr_i,
  input  logic [NrPorts-1:0]                     commit_ack_i,
  input  trace_pkg::priv_lvl_t                   priv_lvl_i,
  input  logic                                   debug_mode_i,
  input  logic [NrPorts-1:0]                     full_i,
  output trace_pkg::trace_rec_t [NrPorts-1:0]    rec_o,
  output logic [NrPorts-1:0]                     push_o,
  output logic [15:0]                            drop_count_o
);

  localparam int unsigned CntW = $clog2(NrPorts + 1);

  logic [trace_pkg::CycleWidth-1:0]    cycle_q;
  trace_pkg::trace_mode_t              mode;
  trace_pkg::trace_rec_t [NrPorts-1:0] rec_d, rec_q;
  logic [NrPorts-1:0]                  valid_q;
  logic [NrPorts-1:0]                  blocked;
  logic [CntW-1:0]                     blocked_cnt;
  logic [16:0]                         drop_sum;
  logic [15:0]                         drop_q;

  // Debug mode overrides the privilege level
  always_comb begin
    case (priv_lvl_i)
      trace_pkg::PRIV_LVL_M: mode = trace_pkg::MODE_M;
      trace_pkg::PRIV_LVL_S: mode = trace_pkg::MODE_S;
      default:               mode = trace_pkg::MODE_U;
    endcase
    if (debug_mode_i) mode = trace_pkg::MODE_D;
  end

  always_comb begin
    for (int i = 0; i < NrPorts; i++) begin
      rec_d[i].cycle    = cycle_q;
      rec_d[i].pc       = commit_instr_i[i].pc;
      rec_d[i].insn     = commit_instr_i[i].tval[31:0];
      rec_d[i].mode     = mode;
      rec_d[i].ex_valid = commit_instr_i[i].ex_valid;
      rec_d[i].cause    = commit_instr_i[i].cause;
    end
  end

  // --------------------------------------------------
  // Push stage, one cycle after the ack
  // --------------------------------------------------
  assign push_o  = valid_q & ~full_i;
  assign blocked = valid_q & full_i;
  assign rec_o   = rec_q;

  always_comb begin
    blocked_cnt = '0;
    for (int i = 0; i < NrPorts; i++) begin
      blocked_cnt = blocked_cnt + CntW'(blocked[i]);
    end
  end

  assign drop_sum     = {1'b0, drop_q} + 17'(blocked_cnt);
  assign drop_count_o = drop_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
      valid_q <= '0;
      drop_q  <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      valid_q <= commit_ack_i;
      // Sticks at all ones once it wraps
      drop_q  <= drop_sum[16] ? 16'hffff : drop_sum[15:0];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NrPorts; i++) begin
      if (commit_ack_i[i]) rec_q[i] <= rec_d[i];
    end
  end

  ack_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(commit_ack_i));

endmodule

// ==== source/trace_pkg.sv ====
/* Shared trace parameters, privilege and mode encodings,
   commit entry and trace record structs */

package trace_pkg;

  // --------------------------------------------------
  // Default sizing
  // --------------------------------------------------
  parameter int unsigned NrCommitPorts = 2;
  parameter int unsigned FifoDepth     = 4;
  parameter int unsigned CycleWidth    = 32;

  // Privilege level of the hart
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  // Mode code as written into a trace record
  typedef enum logic [1:0] {
    MODE_U,
    MODE_S,
    MODE_M,
    MODE_D
  } trace_mode_t;

  // --------------------------------------------------
  // Commit side and trace side records
  // --------------------------------------------------
  typedef struct packed {
    logic [63:0] pc;
    logic [63:0] tval;
    logic        ex_valid;
    logic [7:0]  cause;
  } commit_entry_t;

  typedef struct packed {
    logic [CycleWidth-1:0] cycle;
    logic [63:0]           pc;
    logic [31:0]           insn;     // low word of tval
    trace_mode_t           mode;
    logic                  ex_valid;
    logic [7:0]            cause;
  } trace_rec_t;

endpackage
